//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = ooo_core_tb
FILELIST  = src.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^Finished with no errors$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- src.f
src/ooo_pkg.sv
src/reg_status.sv
src/issue_unit.sv
src/alu_station.sv
src/reorder_buffer.sv
src/ooo_core.sv
tests/ooo_core_props.sv
tests/ooo_core_tb.sv

//--- src/alu_station.sv
`timescale 1ns/1ps

module alu_station (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          load,
    input  ooo_pkg::alu_op_t              op,
    input  logic [ooo_pkg::tag_w-1:0]     tag,
    input  logic [ooo_pkg::xlen-1:0]      vj,
    input  logic [ooo_pkg::tag_w-1:0]     qj,
    input  logic [ooo_pkg::xlen-1:0]      vk,
    input  logic [ooo_pkg::tag_w-1:0]     qk,
    input  logic                          cdb_valid,
    input  logic [ooo_pkg::tag_w-1:0]     cdb_tag,
    input  logic [ooo_pkg::xlen-1:0]      cdb_data,
    output logic                          done,
    output logic [ooo_pkg::xlen-1:0]      result,
    output logic [ooo_pkg::tag_w-1:0]     result_tag,
    input  logic                          grant,
    output logic                          credit
);

    logic                         busy;
    ooo_pkg::alu_op_t             op_q;
    logic [ooo_pkg::xlen-1:0]     vj_q;
    logic [ooo_pkg::xlen-1:0]     vk_q;
    logic [ooo_pkg::tag_w-1:0]    qj_q;
    logic [ooo_pkg::tag_w-1:0]    qk_q;
    logic [ooo_pkg::xlen-1:0]     alu_out;

    assign credit = done && grant;

    always_comb begin
        case (op_q)
            ooo_pkg::alu_sub: alu_out = vj_q - vk_q;
            ooo_pkg::alu_xor: alu_out = vj_q ^ vk_q;
            ooo_pkg::alu_or:  alu_out = vj_q | vk_q;
            ooo_pkg::alu_and: alu_out = vj_q & vk_q;
            default:          alu_out = vj_q + vk_q;
        endcase
    end

    // ****************************************
    // Entry state.
    // ****************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            done <= 1'b0;
        end else if (load) begin
            busy <= 1'b1;
            done <= 1'b0;
        end else if (credit) begin
            busy <= 1'b0;
            done <= 1'b0;
        end else if (busy && !done && qj_q == '0 && qk_q == '0) begin
            done <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            op_q       <= op;
            result_tag <= tag;
            vj_q       <= vj;
            qj_q       <= qj;
            vk_q       <= vk;
            qk_q       <= qk;
            // Broadcast in the load cycle is caught here.
            if (qj != '0 && cdb_valid && cdb_tag == qj) begin
                vj_q <= cdb_data;
                qj_q <= '0;
            end
            if (qk != '0 && cdb_valid && cdb_tag == qk) begin
                vk_q <= cdb_data;
                qk_q <= '0;
            end
        end else begin
            if (qj_q != '0 && cdb_valid && cdb_tag == qj_q) begin
                vj_q <= cdb_data;
                qj_q <= '0;
            end
            if (qk_q != '0 && cdb_valid && cdb_tag == qk_q) begin
                vk_q <= cdb_data;
                qk_q <= '0;
            end
        end
        if (busy && !done) begin
            result <= alu_out;
        end
    end

endmodule

//--- src/issue_unit.sv
`timescale 1ns/1ps

module issue_unit (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 inst_valid,
    input  ooo_pkg::inst_word_t                  inst_word,
    output logic                                 inst_ready,
    output logic [ooo_pkg::reg_addr_w-1:0]       rs1,
    output logic [ooo_pkg::reg_addr_w-1:0]       rs2,
    input  logic [ooo_pkg::xlen-1:0]             rs1_val,
    input  logic [ooo_pkg::xlen-1:0]             rs2_val,
    input  logic [ooo_pkg::tag_w-1:0]            rs1_tag,
    input  logic [ooo_pkg::tag_w-1:0]            rs2_tag,
    output logic                                 rename_valid,
    output logic [ooo_pkg::reg_addr_w-1:0]       rename_rd,
    output logic [ooo_pkg::tag_w-1:0]            rename_tag,
    input  logic [ooo_pkg::tag_w-1:0]            alloc_tag,
    output logic                                 alloc_valid,
    output logic [ooo_pkg::tag_w-1:0]            lookup_tag_j,
    output logic [ooo_pkg::tag_w-1:0]            lookup_tag_k,
    input  logic                                 lookup_done_j,
    input  logic                                 lookup_done_k,
    input  logic [ooo_pkg::xlen-1:0]             lookup_data_j,
    input  logic [ooo_pkg::xlen-1:0]             lookup_data_k,
    input  logic [ooo_pkg::num_stations-1:0]     station_credit,
    input  logic                                 rob_credit,
    output logic [ooo_pkg::num_stations-1:0]     disp_valid,
    output ooo_pkg::alu_op_t                     disp_op,
    output logic [ooo_pkg::tag_w-1:0]            disp_tag,
    output logic [ooo_pkg::xlen-1:0]             disp_vj,
    output logic [ooo_pkg::tag_w-1:0]            disp_qj,
    output logic [ooo_pkg::xlen-1:0]             disp_vk,
    output logic [ooo_pkg::tag_w-1:0]            disp_qk
);

    logic [ooo_pkg::num_stations-1:0] credits;
    logic [ooo_pkg::num_stations-1:0] sel;
    logic [ooo_pkg::tag_w-1:0]        rob_free;
    logic                             is_op;
    logic                             fire;

    // ****************************************
    // Decode.
    // ****************************************
    assign is_op = inst_word.r.opcode == ooo_pkg::opcode_op;
    assign rs1   = inst_word.r.rs1;
    assign rs2   = inst_word.r.rs2;

    always_comb begin
        case (inst_word.r.funct3)
            3'b100:  disp_op = ooo_pkg::alu_xor;
            3'b110:  disp_op = ooo_pkg::alu_or;
            3'b111:  disp_op = ooo_pkg::alu_and;
            default: disp_op = (is_op && inst_word.r.funct7[5]) ? ooo_pkg::alu_sub
                                                               : ooo_pkg::alu_add;
        endcase
    end

    // Operand resolution: register, then reorder buffer, else wait on the tag.
    assign lookup_tag_j = rs1_tag;
    assign lookup_tag_k = rs2_tag;

    always_comb begin
        disp_vj = rs1_val;
        disp_qj = '0;
        if (rs1_tag != '0) begin
            disp_vj = lookup_data_j;
            disp_qj = lookup_done_j ? '0 : rs1_tag;
        end
        disp_vk = rs2_val;
        disp_qk = '0;
        if (!is_op) begin
            disp_vk = {{(ooo_pkg::xlen - 12){inst_word.i.imm[11]}}, inst_word.i.imm};
        end else if (rs2_tag != '0) begin
            disp_vk = lookup_data_k;
            disp_qk = lookup_done_k ? '0 : rs2_tag;
        end
    end

    // ****************************************
    // Station pick and credits.
    // ****************************************
    always_comb begin
        sel = '0;
        for (int s = ooo_pkg::num_stations - 1; s >= 0; s--) begin
            if (credits[s]) begin
                sel    = '0;
                sel[s] = 1'b1;
            end
        end
    end

    assign inst_ready   = (|credits) && (rob_free != '0);
    assign fire         = inst_valid && inst_ready;
    assign disp_valid   = fire ? sel : '0;
    assign disp_tag     = alloc_tag;
    assign alloc_valid  = fire;
    assign rename_valid = fire;
    assign rename_rd    = inst_word.r.rd;
    assign rename_tag   = alloc_tag;

    always_ff @(posedge clk) begin
        if (rst) begin
            credits  <= '1;
            rob_free <= ooo_pkg::tag_w'(ooo_pkg::rob_depth);
        end else begin
            credits <= (credits & ~disp_valid) | station_credit;
            case ({fire, rob_credit})
                2'b10:   rob_free <= rob_free - 1'b1;
                2'b01:   rob_free <= rob_free + 1'b1;
                default: rob_free <= rob_free;
            endcase
        end
    end

endmodule

//--- src/ooo_core.sv
`timescale 1ns/1ps

module ooo_core (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             inst_valid,
    input  ooo_pkg::inst_word_t              inst_word,
    output logic                             inst_ready,
    output logic                             commit_valid,
    output logic [ooo_pkg::reg_addr_w-1:0]   commit_rd,
    output logic [ooo_pkg::xlen-1:0]         commit_data
);

    logic [ooo_pkg::reg_addr_w-1:0]   rs1;
    logic [ooo_pkg::reg_addr_w-1:0]   rs2;
    logic [ooo_pkg::xlen-1:0]         rs1_val;
    logic [ooo_pkg::xlen-1:0]         rs2_val;
    logic [ooo_pkg::tag_w-1:0]        rs1_tag;
    logic [ooo_pkg::tag_w-1:0]        rs2_tag;
    logic                             rename_valid;
    logic [ooo_pkg::reg_addr_w-1:0]   rename_rd;
    logic [ooo_pkg::tag_w-1:0]        rename_tag;
    logic                             alloc_valid;
    logic [ooo_pkg::tag_w-1:0]        alloc_tag;
    logic [ooo_pkg::tag_w-1:0]        lookup_tag_j;
    logic [ooo_pkg::tag_w-1:0]        lookup_tag_k;
    logic                             lookup_done_j;
    logic                             lookup_done_k;
    logic [ooo_pkg::xlen-1:0]         lookup_data_j;
    logic [ooo_pkg::xlen-1:0]         lookup_data_k;
    logic [ooo_pkg::num_stations-1:0] station_credit;
    logic [ooo_pkg::num_stations-1:0] station_done;
    logic [ooo_pkg::xlen-1:0]         station_result [ooo_pkg::num_stations];
    logic [ooo_pkg::tag_w-1:0]        station_tag [ooo_pkg::num_stations];
    logic [ooo_pkg::num_stations-1:0] grant;
    logic                             rob_credit;
    logic [ooo_pkg::num_stations-1:0] disp_valid;
    ooo_pkg::alu_op_t                 disp_op;
    logic [ooo_pkg::tag_w-1:0]        disp_tag;
    logic [ooo_pkg::xlen-1:0]         disp_vj;
    logic [ooo_pkg::tag_w-1:0]        disp_qj;
    logic [ooo_pkg::xlen-1:0]         disp_vk;
    logic [ooo_pkg::tag_w-1:0]        disp_qk;
    logic                             cdb_valid;
    logic [ooo_pkg::tag_w-1:0]        cdb_tag;
    logic [ooo_pkg::xlen-1:0]         cdb_data;
    logic [ooo_pkg::tag_w-1:0]        commit_tag;

    reg_status u_regs (
        .clk, .rst, .rs1, .rs2, .rs1_val, .rs2_val, .rs1_tag, .rs2_tag,
        .rename_valid, .rename_rd, .rename_tag,
        .commit_valid, .commit_rd, .commit_data, .commit_tag
    );

    issue_unit u_issue (
        .clk, .rst, .inst_valid, .inst_word, .inst_ready,
        .rs1, .rs2, .rs1_val, .rs2_val, .rs1_tag, .rs2_tag,
        .rename_valid, .rename_rd, .rename_tag, .alloc_tag, .alloc_valid,
        .lookup_tag_j, .lookup_tag_k, .lookup_done_j, .lookup_done_k,
        .lookup_data_j, .lookup_data_k, .station_credit, .rob_credit,
        .disp_valid, .disp_op, .disp_tag, .disp_vj, .disp_qj, .disp_vk, .disp_qk
    );

    reorder_buffer u_rob (
        .clk, .rst, .alloc_valid, .alloc_rd(rename_rd), .alloc_tag,
        .lookup_tag_j, .lookup_tag_k, .lookup_done_j, .lookup_done_k,
        .lookup_data_j, .lookup_data_k,
        .station_done, .station_result, .station_tag, .grant,
        .cdb_valid, .cdb_tag, .cdb_data,
        .commit_valid, .commit_rd, .commit_data, .commit_tag, .rob_credit
    );

    // ****************************************
    // ALU stations.
    // ****************************************
    for (genvar s = 0; s < ooo_pkg::num_stations; s++) begin : g_station
        alu_station u_station (
            .clk, .rst, .load(disp_valid[s]), .op(disp_op), .tag(disp_tag),
            .vj(disp_vj), .qj(disp_qj), .vk(disp_vk), .qk(disp_qk),
            .cdb_valid, .cdb_tag, .cdb_data,
            .done(station_done[s]), .result(station_result[s]),
            .result_tag(station_tag[s]), .grant(grant[s]), .credit(station_credit[s])
        );
    end

endmodule

//--- src/ooo_pkg.sv
package ooo_pkg;

    // ****************************************
    // Sizes.
    // ****************************************
    localparam int xlen         = 32;
    localparam int num_regs     = 32;
    localparam int reg_addr_w   = 5;
    localparam int rob_depth    = 8;
    localparam int rob_ptr_w    = 3;
    localparam int tag_w        = 4;
    localparam int num_stations = 4;

    // ****************************************
    // Instruction encoding.
    // ****************************************
    localparam logic [6:0] opcode_op     = 7'b0110011;
    localparam logic [6:0] opcode_op_imm = 7'b0010011;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_xor,
        alu_or,
        alu_and
    } alu_op_t;

    typedef struct packed {
        logic [6:0]            funct7;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } r_fields_t;

    typedef struct packed {
        logic [11:0]           imm;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } i_fields_t;

    // Same word, read as R-type or I-type.
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
    } inst_word_t;

endpackage

//--- src/reg_status.sv
`timescale 1ns/1ps

module reg_status (
    input  logic                               clk,
    input  logic                               rst,
    input  logic [ooo_pkg::reg_addr_w-1:0]     rs1,
    input  logic [ooo_pkg::reg_addr_w-1:0]     rs2,
    output logic [ooo_pkg::xlen-1:0]           rs1_val,
    output logic [ooo_pkg::xlen-1:0]           rs2_val,
    output logic [ooo_pkg::tag_w-1:0]          rs1_tag,
    output logic [ooo_pkg::tag_w-1:0]          rs2_tag,
    input  logic                               rename_valid,
    input  logic [ooo_pkg::reg_addr_w-1:0]     rename_rd,
    input  logic [ooo_pkg::tag_w-1:0]          rename_tag,
    input  logic                               commit_valid,
    input  logic [ooo_pkg::reg_addr_w-1:0]     commit_rd,
    input  logic [ooo_pkg::xlen-1:0]           commit_data,
    input  logic [ooo_pkg::tag_w-1:0]          commit_tag
);

    logic [ooo_pkg::xlen-1:0]  vals [ooo_pkg::num_regs];
    logic [ooo_pkg::tag_w-1:0] tags [ooo_pkg::num_regs];

    // Reads are combinational.
    assign rs1_val = vals[rs1];
    assign rs2_val = vals[rs2];
    assign rs1_tag = tags[rs1];
    assign rs2_tag = tags[rs2];

    // ****************************************
    // Commit and rename.
    // ****************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < ooo_pkg::num_regs; i++) begin
                vals[i] <= '0;
                tags[i] <= '0;
            end
        end else begin
            if (commit_valid && commit_rd != '0) begin
                vals[commit_rd] <= commit_data;
                // Only the newest producer releases the register.
                if (tags[commit_rd] == commit_tag) begin
                    tags[commit_rd] <= '0;
                end
            end
            // Later assignment wins over the clear above.
            if (rename_valid && rename_rd != '0) begin
                tags[rename_rd] <= rename_tag;
            end
        end
    end

endmodule

//--- src/reorder_buffer.sv
`timescale 1ns/1ps

module reorder_buffer (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               alloc_valid,
    input  logic [ooo_pkg::reg_addr_w-1:0]     alloc_rd,
    output logic [ooo_pkg::tag_w-1:0]          alloc_tag,
    input  logic [ooo_pkg::tag_w-1:0]          lookup_tag_j,
    input  logic [ooo_pkg::tag_w-1:0]          lookup_tag_k,
    output logic                               lookup_done_j,
    output logic                               lookup_done_k,
    output logic [ooo_pkg::xlen-1:0]           lookup_data_j,
    output logic [ooo_pkg::xlen-1:0]           lookup_data_k,
    input  logic [ooo_pkg::num_stations-1:0]   station_done,
    input  logic [ooo_pkg::xlen-1:0]           station_result [ooo_pkg::num_stations],
    input  logic [ooo_pkg::tag_w-1:0]          station_tag [ooo_pkg::num_stations],
    output logic [ooo_pkg::num_stations-1:0]   grant,
    output logic                               cdb_valid,
    output logic [ooo_pkg::tag_w-1:0]          cdb_tag,
    output logic [ooo_pkg::xlen-1:0]           cdb_data,
    output logic                               commit_valid,
    output logic [ooo_pkg::reg_addr_w-1:0]     commit_rd,
    output logic [ooo_pkg::xlen-1:0]           commit_data,
    output logic [ooo_pkg::tag_w-1:0]          commit_tag,
    output logic                               rob_credit
);

    logic [ooo_pkg::reg_addr_w-1:0] rd_q   [ooo_pkg::rob_depth];
    logic [ooo_pkg::xlen-1:0]       data_q [ooo_pkg::rob_depth];
    logic [ooo_pkg::rob_depth-1:0]  done_q;
    logic [ooo_pkg::rob_ptr_w-1:0]  head;
    logic [ooo_pkg::rob_ptr_w-1:0]  tail;
    logic [ooo_pkg::tag_w-1:0]      cdb_slot;
    logic [ooo_pkg::tag_w-1:0]      j_slot;
    logic [ooo_pkg::tag_w-1:0]      k_slot;

    // Tag k names slot k-1.
    assign alloc_tag = {1'b0, tail} + 1'b1;
    assign cdb_slot  = cdb_tag - 1'b1;
    assign j_slot    = lookup_tag_j - 1'b1;
    assign k_slot    = lookup_tag_k - 1'b1;

    // ****************************************
    // Data bus arbitration, lowest first.
    // ****************************************
    assign cdb_valid = |station_done;

    always_comb begin
        grant    = '0;
        cdb_tag  = '0;
        cdb_data = '0;
        for (int s = ooo_pkg::num_stations - 1; s >= 0; s--) begin
            if (station_done[s]) begin
                grant    = '0;
                grant[s] = 1'b1;
                cdb_tag  = station_tag[s];
                cdb_data = station_result[s];
            end
        end
    end

    // Lookups see the current broadcast too.
    always_comb begin
        lookup_done_j = done_q[j_slot[ooo_pkg::rob_ptr_w-1:0]];
        lookup_data_j = data_q[j_slot[ooo_pkg::rob_ptr_w-1:0]];
        if (cdb_valid && cdb_tag == lookup_tag_j) begin
            lookup_done_j = 1'b1;
            lookup_data_j = cdb_data;
        end
        lookup_done_k = done_q[k_slot[ooo_pkg::rob_ptr_w-1:0]];
        lookup_data_k = data_q[k_slot[ooo_pkg::rob_ptr_w-1:0]];
        if (cdb_valid && cdb_tag == lookup_tag_k) begin
            lookup_done_k = 1'b1;
            lookup_data_k = cdb_data;
        end
    end

    // ****************************************
    // In-order commit.
    // ****************************************
    assign commit_valid = done_q[head];
    assign commit_rd    = rd_q[head];
    assign commit_data  = data_q[head];
    assign commit_tag   = {1'b0, head} + 1'b1;
    assign rob_credit   = commit_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            done_q <= '0;
            head   <= '0;
            tail   <= '0;
        end else begin
            if (commit_valid) begin
                done_q[head] <= 1'b0;
                head         <= head + 1'b1;
            end
            if (alloc_valid) begin
                done_q[tail] <= 1'b0;
                tail         <= tail + 1'b1;
            end
            if (cdb_valid) begin
                done_q[cdb_slot[ooo_pkg::rob_ptr_w-1:0]] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_valid) begin
            rd_q[tail] <= alloc_rd;
        end
        if (cdb_valid) begin
            data_q[cdb_slot[ooo_pkg::rob_ptr_w-1:0]] <= cdb_data;
        end
    end

endmodule

//--- tests/ooo_core_props.sv
`timescale 1ns/1ps

module ooo_core_props (
    input logic                             clk,
    input logic                             rst,
    input logic                             inst_valid,
    input logic                             inst_ready,
    input logic                             commit_valid,
    input logic                             cdb_valid,
    input logic [ooo_pkg::num_stations-1:0] grant
);

    // Accepted instructions not yet committed.
    logic [7:0] pending;

    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= '0;
        end else begin
            pending <= pending + 8'(inst_valid && inst_ready) - 8'(commit_valid);
        end
    end

    quiet_after_reset: assert property (@(posedge clk) rst |=> !commit_valid)
        else $error("commit_valid high during or right after reset");

    ready_when_empty: assert property (@(posedge clk) disable iff (rst)
        (pending == '0) |-> inst_ready)
        else $error("inst_ready low with nothing in flight");

    single_grant: assert property (@(posedge clk) disable iff (rst)
        cdb_valid |-> $onehot(grant))
        else $error("data bus valid without exactly one grant");

endmodule

bind ooo_core ooo_core_props u_props (
    .clk, .rst, .inst_valid, .inst_ready, .commit_valid, .cdb_valid, .grant
);

//--- tests/ooo_core_tb.sv
`timescale 1ns/1ps

module ooo_core_tb;

    localparam int wait_limit = 400;

    logic                           clk;
    logic                           rst;
    logic                           inst_valid;
    ooo_pkg::inst_word_t            inst_word;
    logic                           inst_ready;
    logic                           commit_valid;
    logic [ooo_pkg::reg_addr_w-1:0] commit_rd;
    logic [ooo_pkg::xlen-1:0]       commit_data;

    logic [ooo_pkg::xlen-1:0]       model_regs [ooo_pkg::num_regs];
    logic [ooo_pkg::reg_addr_w-1:0] exp_rd [$];
    logic [ooo_pkg::xlen-1:0]       exp_data [$];
    logic [31:0]                    lcg_state;
    int                             errors;

    ooo_core DUT (
        .clk, .rst, .inst_valid, .inst_word, .inst_ready,
        .commit_valid, .commit_rd, .commit_data
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state ^ (lcg_state >> 16);
    endfunction

    function automatic ooo_pkg::inst_word_t enc_r(int funct7, int rs2, int rs1, int funct3,
            int rd);
        ooo_pkg::inst_word_t w;
        w.r = '{7'(funct7), 5'(rs2), 5'(rs1), 3'(funct3), 5'(rd), ooo_pkg::opcode_op};
        return w;
    endfunction

    function automatic ooo_pkg::inst_word_t enc_i(int imm, int rs1, int funct3, int rd);
        ooo_pkg::inst_word_t w;
        w.i = '{12'(imm), 5'(rs1), 3'(funct3), 5'(rd), ooo_pkg::opcode_op_imm};
        return w;
    endfunction

    // ****************************************
    // Reference model.
    // ****************************************
    function automatic logic [31:0] ref_exec(ooo_pkg::inst_word_t w);
        logic        is_r;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        is_r = w.r.opcode == ooo_pkg::opcode_op;
        a = model_regs[w.r.rs1];
        b = is_r ? model_regs[w.r.rs2] : {{20{w.i.imm[11]}}, w.i.imm};
        case (w.r.funct3)
            3'b100:  res = a ^ b;
            3'b110:  res = a | b;
            3'b111:  res = a & b;
            default: res = (is_r && w.r.funct7[5]) ? a - b : a + b;
        endcase
        // x0 stays zero.
        if (w.r.rd != '0) begin
            model_regs[w.r.rd] = res;
        end
        return res;
    endfunction

    function automatic ooo_pkg::inst_word_t rand_inst(int lo, int nregs);
        logic [31:0] sel;
        int          rd;
        int          rs1;
        int          rs2;
        int          imm;
        sel = next_rand() % 9;
        rd  = lo + int'(next_rand() % nregs);
        rs1 = lo + int'(next_rand() % nregs);
        rs2 = lo + int'(next_rand() % nregs);
        imm = int'(next_rand() % 4096);
        case (sel)
            0:       return enc_r(0, rs2, rs1, 3'b000, rd);
            1:       return enc_r(32, rs2, rs1, 3'b000, rd);
            2:       return enc_r(0, rs2, rs1, 3'b100, rd);
            3:       return enc_r(0, rs2, rs1, 3'b110, rd);
            4:       return enc_r(0, rs2, rs1, 3'b111, rd);
            5:       return enc_i(imm, rs1, 3'b000, rd);
            6:       return enc_i(imm, rs1, 3'b100, rd);
            7:       return enc_i(imm, rs1, 3'b110, rd);
            default: return enc_i(imm, rs1, 3'b111, rd);
        endcase
    endfunction

    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic finish_run();
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    endtask

    task automatic give_up(string what);
        errors++;
        $display("Timeout at %0t ns while waiting for %s", $time, what);
        finish_run();
    endtask

    // Holds the word until the core takes it, then records the expected commit.
    task automatic send(ooo_pkg::inst_word_t w);
        int   waited;
        logic taken;
        waited = 0;
        taken = 1'b0;
        inst_valid = 1'b1;
        inst_word = w;
        while (!taken) begin
            @(negedge clk);
            taken = inst_ready;
            @(posedge clk);
            #2;
            waited++;
            if (!taken && waited > wait_limit) begin
                give_up("inst_ready");
            end
        end
        exp_rd.push_back(w.r.rd);
        exp_data.push_back(ref_exec(w));
    endtask

    task automatic idle(int cycles);
        inst_valid = 1'b0;
        repeat (cycles) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_rd.size() != 0) begin
            @(posedge clk);
            #2;
            waited++;
            if (waited > wait_limit) begin
                give_up("outstanding commits");
            end
        end
    endtask

    // Commit stream against the expected queue.
    always @(negedge clk) begin
        if (!rst && commit_valid) begin
            if (exp_rd.size() == 0) begin
                errors++;
                $display("ERROR at %0t ns: commit with no instruction outstanding", $time);
            end else begin
                check_value("commit_rd", commit_rd, exp_rd.pop_front());
                check_value("commit_data", commit_data, exp_data.pop_front());
            end
        end
    end

    // ****************************************
    // Stimulus.
    // ****************************************
    initial begin
        clk = 1'b0;
        rst = 1'b1;
        inst_valid = 1'b0;
        inst_word = '0;
        errors = 0;
        lcg_state = 32'd5;
        for (int i = 0; i < ooo_pkg::num_regs; i++) begin
            model_regs[i] = '0;
        end
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;

        // Independent ADDI with negative immediates too.
        send(enc_i(5, 0, 3'b000, 1));
        send(enc_i(-1, 0, 3'b000, 2));
        send(enc_i(2047, 0, 3'b000, 3));
        send(enc_i(-2048, 0, 3'b000, 4));
        send(enc_i(100, 0, 3'b000, 5));
        send(enc_i(-300, 0, 3'b000, 6));
        idle(2);

        // Dependent chain.
        send(enc_i(10, 0, 3'b000, 7));
        send(enc_r(0, 7, 7, 3'b000, 8));
        send(enc_r(32, 7, 8, 3'b000, 9));
        send(enc_r(0, 8, 9, 3'b000, 10));
        send(enc_r(32, 2, 10, 3'b000, 11));
        send(enc_r(0, 11, 11, 3'b000, 12));
        idle(3);

        // Logic operations on random operands.
        for (int i = 0; i < 4; i++) begin
            send(enc_i(int'(next_rand() % 4096), 0, 3'b000, 13 + i));
        end
        for (int i = 0; i < 24; i++) begin
            send(rand_inst(13, 8));
        end
        idle(2);

        // Writes to x0 are dropped.
        send(enc_i(7, 3, 3'b000, 0));
        send(enc_r(0, 2, 1, 3'b000, 0));
        send(enc_r(0, 0, 0, 3'b000, 21));
        send(enc_i(0, 0, 3'b110, 22));
        idle(2);

        // Burst beyond the reorder-buffer depth.
        for (int i = 0; i < 20; i++) begin
            send(enc_i(i * 3 - 20, 1 + (i + 7) % 8, 3'b000, 1 + i % 8));
        end
        idle(1);
        wait_drain();

        // Long random stream over x0 to x7.
        for (int i = 0; i < 200; i++) begin
            send(rand_inst(0, 8));
            if (next_rand() % 5 == 0) begin
                idle(1 + int'(next_rand() % 3));
            end
        end
        idle(1);
        wait_drain();
        idle(4);
        finish_run();
    end

endmodule
